//--- cache_subsystem.f
verilog/cache_pkg.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache_miss_table.sv
verilog/cache_bank.sv
verilog/cache_output_align.sv
verilog/cache_subsystem.sv
verif/cache_scoreboard.sv
verif/cache_subsystem_checker.sv
verif/cache_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
  -f cache_subsystem.f --top-module cache_subsystem_tb -o sim_cache

./obj_dir/sim_cache 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- verif/cache_golden.txt
# test op uncached addr(hex) size wdata(hex) expected(hex)
# op: 0 load, 1 store, 2 expect bus write of line, 3 wait for all responses
1 0 0 0100 3 0 342d261f18110a03
1 0 0 0108 2 0 5049423b
1 0 0 010c 1 0 5e57
1 0 0 010f 0 0 6c
1 0 0 0106 1 0 342d
2 1 0 0220 0 aa 0
2 1 0 0222 1 bbcc 0
2 1 0 0224 2 11223344 0
2 1 0 0228 3 0102030405060708 0
2 1 0 0230 1 beef 0
2 0 0 0220 3 0 11223344bbcceaaa
2 0 0 0228 3 0 0102030405060708
2 0 0 0221 0 0 ea
2 0 0 022a 1 0 0506
2 0 0 0230 3 0 847d766f6861beef
3 1 0 0410 3 a0a0a0a0a0a0a001 0
3 1 0 0450 3 a0a0a0a0a0a0a002 0
3 1 0 0490 3 a0a0a0a0a0a0a003 0
3 1 0 04d0 3 a0a0a0a0a0a0a004 0
3 1 0 0510 3 a0a0a0a0a0a0a005 0
3 3 0 0000 0 0 0
3 2 0 0410 0 0 0
3 0 0 0410 3 0 a0a0a0a0a0a0a001
3 0 0 0418 3 0 dcd5cec7c0b9b2ab
4 0 1 6010 3 0 a49d968f88817a73
4 1 1 6014 2 deadbeef 0
4 0 1 6010 3 0 deadbeef88817a73
4 0 1 6016 0 0 ad
4 1 1 6008 0 5a 0
4 0 1 6008 3 0 6c655e575049425a
5 0 0 0730 0 0 53
5 3 0 0000 0 0 0
5 0 0 0800 3 0 342d261f18110a03
5 0 0 0840 2 0 d8d1cac3
5 0 0 0734 2 0 847d766f
5 0 0 0880 1 0 8a83
5 0 0 0808 0 0 3b

//--- verif/cache_scoreboard.sv
`timescale 1ns/10ps

module cache_scoreboard import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req_valid,
  input  logic              req_ready,
  input  cache_req_t        req,
  input  logic [63:0]       exp_data,
  input  logic              resp_valid,
  input  cache_resp_t       resp,
  input  logic              bus_req_valid,
  input  logic              bus_req_ready,
  input  bus_req_t          bus_req,
  input  logic              wb_exp_valid,
  input  logic [ADDR_W-1:0] wb_exp_addr,
  input  logic              test_end,
  input  int                test_num,
  output int                outstanding,
  output int                errors,
  output int                checks,
  output int                tests
);

  logic              pend      [16];
  logic              pend_wr   [16];
  logic [63:0]       pend_data [16];
  logic [ADDR_W-1:0] writes_seen [$];
  logic [ADDR_W-1:0] writes_exp  [$];
  int                unc_exp;
  int                unc_seen;
  int                test_errors;

  initial begin
    for (int i = 0; i < 16; i++) begin
      pend[i] = 1'b0;
    end
    outstanding = 0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    unc_exp     = 0;
    unc_seen    = 0;
    test_errors = 0;
  end

  task automatic flag_error();
    errors++;
    test_errors++;
  endtask

  // Every signal sampled mid-cycle, where it is stable
  always @(negedge clk) begin
    if (arst_n) begin
      if (resp_valid) begin
        checks++;
        if (!pend[resp.id]) begin
          $display("response with id %0h arrived with no request waiting", resp.id);
          flag_error();
        end else begin
          if (resp.data !== pend_data[resp.id]) begin
            $display("mismatch resp.data id %h: got %h expected %h",
                     resp.id, resp.data, pend_data[resp.id]);
            flag_error();
          end
          if (resp.write !== pend_wr[resp.id]) begin
            $display("mismatch resp.write id %h: got %h expected %h",
                     resp.id, resp.write, pend_wr[resp.id]);
            flag_error();
          end
          pend[resp.id] = 1'b0;
          outstanding--;
        end
      end
      if (req_valid && req_ready) begin
        pend[req.id]      = 1'b1;
        pend_wr[req.id]   = req.write;
        pend_data[req.id] = exp_data;
        outstanding++;
        if (req.uncached) begin
          unc_exp++;
        end
      end
      if (bus_req_valid && bus_req_ready) begin
        if (bus_req.write) begin
          writes_seen.push_back(bus_req.addr);
        end
        if (bus_req.addr >= 15'h6000) begin
          unc_seen++;
        end
      end
      if (wb_exp_valid) begin
        writes_exp.push_back(wb_exp_addr);
      end
      if (test_end) begin
        checks++;
        foreach (writes_exp[i]) begin
          if (!(writes_exp[i] inside {writes_seen})) begin
            $display("no bus write seen for line %h", writes_exp[i]);
            flag_error();
          end
        end
        if (unc_seen != unc_exp) begin
          $display("uncached accesses gave %0d bus requests instead of %0d",
                   unc_seen, unc_exp);
          flag_error();
        end
        if (outstanding != 0) begin
          $display("%0d responses still missing at end of test", outstanding);
          flag_error();
        end
        if (test_errors == 0) begin
          $display("test %0d passed", test_num);
        end else begin
          $display("test %0d: %0d errors", test_num, test_errors);
        end
        tests++;
        test_errors = 0;
        unc_exp     = 0;
        unc_seen    = 0;
        writes_seen.delete();
        writes_exp.delete();
      end
    end
  end

endmodule

//--- verif/cache_subsystem_checker.sv
`timescale 1ns/10ps

module cache_subsystem_checker import cache_pkg::*; (
  input logic     clk,
  input logic     arst_n,
  input logic     req_ready,
  input logic     resp_valid,
  input logic     bus_req_valid,
  input logic     bus_req_ready,
  input bus_req_t bus_req,
  input logic     bus_resp_valid
);

  int reads_out;
  int failures;

  // Line reads taken by the bus and not yet answered
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reads_out <= 0;
    end else begin
      reads_out <= reads_out + int'(bus_req_valid && bus_req_ready && !bus_req.write)
                   - int'(bus_resp_valid);
    end
  end

  // Bus request must hold until taken
  bus_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req))
    else begin
      $error("bus request changed while waiting for ready");
      failures++;
    end

  // Outputs quiet right after reset release
  reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> !resp_valid && !bus_req_valid)
    else begin
      $error("valid output high after reset release");
      failures++;
    end

  // Each line read in flight holds one miss table entry
  reads_bounded: assert property (@(posedge clk) disable iff (!arst_n)
    reads_out <= MSHR_DEPTH)
    else begin
      $error("more line reads in flight than miss table entries");
      failures++;
    end

endmodule

bind cache_subsystem cache_subsystem_checker u_checker (.*);

//--- verif/cache_subsystem_tb.sv
`timescale 1ns/10ps

module cache_subsystem_tb import cache_pkg::*; ();

  logic              clk;
  logic              arst_n;
  logic              req_valid;
  logic              req_ready;
  cache_req_t        req;
  logic              resp_valid;
  cache_resp_t       resp;
  logic              bus_req_valid;
  logic              bus_req_ready;
  bus_req_t          bus_req;
  logic              bus_resp_valid;
  bus_resp_t         bus_resp;
  logic [63:0]       exp_data;
  logic              wb_exp_valid;
  logic [ADDR_W-1:0] wb_exp_addr;
  logic              test_end;
  int                test_num;
  int                outstanding;
  int                errors;
  int                checks;
  int                tests;

  // Golden rows
  int                g_test  [$];
  int                g_op    [$];
  int                g_unc   [$];
  int                g_size  [$];
  logic [ADDR_W-1:0] g_addr  [$];
  logic [63:0]       g_wdata [$];
  logic [63:0]       g_exp   [$];
  logic              loaded;

  // Bus memory model
  logic [7:0]        mem [1 << ADDR_W];
  logic [ADDR_W-1:0] rd_addr_q [$];
  int                rd_due_q  [$];
  int                cycle;
  int                fill_delay;
  logic [ID_W-1:0]   next_id;

  cache_subsystem DUT (
    .clk, .arst_n,
    .req_valid, .req_ready, .req,
    .resp_valid, .resp,
    .bus_req_valid, .bus_req_ready, .bus_req,
    .bus_resp_valid, .bus_resp
  );

  cache_scoreboard u_scoreboard (
    .clk, .arst_n,
    .req_valid, .req_ready, .req, .exp_data,
    .resp_valid, .resp,
    .bus_req_valid, .bus_req_ready, .bus_req,
    .wb_exp_valid, .wb_exp_addr, .test_end, .test_num,
    .outstanding, .errors, .checks, .tests
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic load_golden(output logic opened);
    int    fd;
    int    n;
    int    t;
    int    op;
    int    unc;
    int    size;
    int    addr;
    logic [63:0] wdata;
    logic [63:0] expv;
    string line;
    fd = $fopen("verif/cache_golden.txt", "r");
    opened = (fd != 0);
    if (opened) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 2 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %h %d %h %h", t, op, unc, addr, size, wdata, expv);
          if (n == 7) begin
            g_test.push_back(t);
            g_op.push_back(op);
            g_unc.push_back(unc);
            g_addr.push_back(ADDR_W'(addr));
            g_size.push_back(size);
            g_wdata.push_back(wdata);
            g_exp.push_back(expv);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_request(input int i);
    req.id       = next_id;
    req.write    = (g_op[i] == 1);
    req.uncached = (g_unc[i] != 0);
    req.addr     = g_addr[i];
    req.size     = 2'(g_size[i]);
    req.wdata    = g_wdata[i];
    exp_data     = g_exp[i];
    req_valid    = 1'b1;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    next_id++;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (outstanding != 0) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic close_test(input int num);
    test_num = num;
    test_end = 1'b1;
    @(posedge clk);
    #1;
    test_end = 1'b0;
  endtask

  task automatic note_writeback(input logic [ADDR_W-1:0] addr);
    wb_exp_addr  = addr;
    wb_exp_valid = 1'b1;
    @(posedge clk);
    #1;
    wb_exp_valid = 1'b0;
  endtask

  // Reads are answered in order after a random delay
  always @(negedge clk) begin
    if (arst_n && bus_req_valid && bus_req_ready) begin
      if (bus_req.write) begin
        for (int b = 0; b < LINE_BYTES; b++) begin
          if (bus_req.mask[b]) begin
            mem[bus_req.addr + b] = bus_req.line[b*8 +: 8];
          end
        end
      end else begin
        rd_addr_q.push_back(bus_req.addr);
        rd_due_q.push_back(cycle + 1 + fill_delay);
      end
    end
  end

  initial begin
    bus_req_ready  = 1'b0;
    bus_resp_valid = 1'b0;
    bus_resp       = '0;
    cycle          = 0;
    fill_delay     = 0;
    void'($urandom(97));
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      bus_req_ready  = ($urandom % 4) != 0;
      fill_delay     = int'($urandom % 6);
      bus_resp_valid = 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
        bus_resp.addr = rd_addr_q.pop_front();
        void'(rd_due_q.pop_front());
        for (int b = 0; b < LINE_BYTES; b++) begin
          bus_resp.line[b*8 +: 8] = mem[bus_resp.addr + b];
        end
        bus_resp_valid = 1'b1;
      end
    end
  end

  initial begin
    loaded = 1'b0;
    wait (loaded);
    repeat (200 * g_test.size()) @(posedge clk);
    $display("timeout: run did not finish in the allowed cycles");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int   cur;
    logic opened;
    arst_n       = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    exp_data     = '0;
    wb_exp_valid = 1'b0;
    wb_exp_addr  = '0;
    test_end     = 1'b0;
    test_num     = 0;
    next_id      = '0;
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      mem[a] = 8'(a * 7 + 3);
    end
    load_golden(opened);
    if (!opened || g_test.size() == 0) begin
      $display("golden file missing or empty");
      $display("TEST FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      arst_n = 1'b1;
      @(posedge clk);
      #1;
      cur = g_test[0];
      for (int i = 0; i < g_test.size(); i++) begin
        if (g_test[i] != cur) begin
          wait_drain();
          close_test(cur);
          cur = g_test[i];
        end
        case (g_op[i])
          2:       note_writeback(g_addr[i]);
          3:       wait_drain();
          default: send_request(i);
        endcase
      end
      wait_drain();
      close_test(cur);
      repeat (4) @(posedge clk);
      $display("totals: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, DUT.u_checker.failures);
      if (errors == 0 && DUT.u_checker.failures == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

//--- verilog/cache_bank.sv
`timescale 1ns/10ps

module cache_bank import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  req_valid,
  input  cache_req_t            req,
  output logic                  req_ready,
  output logic                  bus_req_valid,
  input  logic                  bus_req_ready,
  output bus_req_t              bus_req,
  input  logic                  bus_resp_valid,
  input  bus_resp_t             bus_resp,
  // Tag array
  output logic [IDX_W-1:0]      lookup_index,
  output logic [TAG_W-1:0]      lookup_tag,
  input  logic                  hit,
  input  logic [WAY_W-1:0]      hit_way,
  input  logic [WAY_W-1:0]      victim_way,
  input  logic                  victim_dirty,
  input  logic [TAG_W-1:0]      victim_tag,
  output logic                  install,
  output logic [WAY_W-1:0]      install_way,
  output logic [TAG_W-1:0]      install_tag,
  output logic                  touch,
  output logic [WAY_W-1:0]      touch_way,
  output logic                  set_dirty,
  // Data array
  output logic [IDX_W-1:0]      rd_index,
  output logic [WAY_W-1:0]      rd_way,
  input  logic [LINE_W-1:0]     rd_line,
  output logic                  wr_en,
  output logic [IDX_W-1:0]      wr_index,
  output logic [WAY_W-1:0]      wr_way,
  output logic [LINE_BYTES-1:0] wr_mask,
  output logic [LINE_W-1:0]     wr_line,
  // Miss table
  output logic                  alloc,
  output cache_req_t            alloc_req,
  input  logic                  full,
  input  logic                  pending_match,
  output logic [ADDR_W-1:0]     probe_addr,
  output logic                  fill,
  output logic [ADDR_W-1:0]     fill_addr,
  input  logic                  head_valid,
  input  cache_req_t            head_req,
  // Output aligner
  output logic                  result_valid,
  output cache_req_t            result_req,
  output logic [LINE_W-1:0]     result_line
);

  logic [OFF_W-1:0]      req_off;
  logic [LINE_BYTES-1:0] req_mask;
  logic [LINE_W-1:0]     req_placed;
  logic [OFF_W-1:0]      head_off;
  logic [LINE_W-1:0]     fill_line;
  logic                  cached_hit;
  logic                  needs_bus;
  logic                  bus_free;
  logic                  wr_wait;
  logic                  ust_block;
  logic                  accept;
  logic                  hit_acc;
  logic                  issue;
  logic                  fill_wb;
  logic                  ust_done;
  bus_req_t              new_bus;

  // Bus output register with the writeback buffer behind it
  logic       bus_q_valid;
  logic       bus_q_ust;
  bus_req_t   bus_q;
  logic       wb_valid;
  bus_req_t   wb_q;
  cache_req_t ust_req;

  assign req_off    = req.addr[OFF_W-1:0];
  assign req_mask   = size_mask(req.size, req_off);
  assign req_placed = place_bytes(req.wdata, req_off);

  assign fill       = bus_resp_valid;
  assign fill_addr  = bus_resp.addr;
  assign probe_addr = req.addr;

  // The arriving fill takes the lookup port for its cycle
  assign lookup_index = fill ? bus_resp.addr[OFF_W +: IDX_W] : req.addr[OFF_W +: IDX_W];
  assign lookup_tag   = fill ? bus_resp.addr[ADDR_W-1 -: TAG_W] : req.addr[ADDR_W-1 -: TAG_W];
  assign rd_index     = lookup_index;
  assign rd_way       = fill ? victim_way : hit_way;

  assign cached_hit = !req.uncached && hit;
  assign needs_bus  = !cached_hit;
  assign bus_free   = !bus_q_valid || bus_req_ready;
  assign wr_wait    = wb_valid || (bus_q_valid && bus_q.write);
  // Uncached stores only go out with no line reads in flight
  assign ust_block  = req.uncached && req.write && head_valid;

  assign req_ready = !full && !pending_match && !wr_wait && !fill && !ust_block &&
                     (bus_free || !needs_bus);

  assign accept  = req_valid && req_ready;
  assign hit_acc = accept && cached_hit;
  assign issue   = accept && needs_bus;

  // Misses and uncached loads wait in the table for their line
  assign alloc     = issue && !(req.uncached && req.write);
  assign alloc_req = req;

  assign touch     = hit_acc;
  assign touch_way = hit_way;
  assign set_dirty = fill ? head_req.write : req.write;

  // Install the returned line, with a waiting store merged in
  assign head_off    = head_req.addr[OFF_W-1:0];
  assign fill_line   = head_req.write ?
                       merge_bytes(bus_resp.line, place_bytes(head_req.wdata, head_off),
                                   size_mask(head_req.size, head_off)) :
                       bus_resp.line;
  assign install     = fill && head_valid && !head_req.uncached;
  assign install_way = victim_way;
  assign install_tag = lookup_tag;
  assign fill_wb     = install && victim_dirty;

  assign wr_en    = install || (hit_acc && req.write);
  assign wr_index = lookup_index;
  assign wr_way   = rd_way;
  assign wr_mask  = install ? '1 : req_mask;
  assign wr_line  = install ? fill_line : req_placed;

  always_comb begin
    new_bus.write = req.uncached && req.write;
    new_bus.addr  = line_of(req.addr);
    new_bus.line  = req_placed;
    new_bus.mask  = new_bus.write ? req_mask : '1;
  end

  assign ust_done = bus_q_valid && bus_req_ready && bus_q_ust;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_q_valid  <= 1'b0;
      bus_q_ust    <= 1'b0;
      wb_valid     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      // Writeback goes ahead of any new request
      if (bus_free) begin
        bus_q_valid <= wb_valid || issue;
        bus_q_ust   <= !wb_valid && issue && new_bus.write;
      end
      wb_valid     <= fill_wb || (wb_valid && !bus_free);
      result_valid <= hit_acc || (fill && head_valid) || ust_done;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_free) begin
      bus_q <= wb_valid ? wb_q : new_bus;
    end
    if (issue && new_bus.write) begin
      ust_req <= req;
    end
    if (fill_wb) begin
      wb_q.write <= 1'b1;
      wb_q.addr  <= {victim_tag, lookup_index, OFF_W'(0)};
      wb_q.line  <= rd_line;
      wb_q.mask  <= '1;
    end
    if (fill) begin
      result_req  <= head_req;
      result_line <= fill_line;
    end else if (ust_done) begin
      result_req  <= ust_req;
      result_line <= '0;
    end else begin
      result_req  <= req;
      result_line <= rd_line;
    end
  end

  assign bus_req_valid = bus_q_valid;
  assign bus_req       = bus_q;

endmodule

//--- verilog/cache_data_array.sv
`timescale 1ns/10ps

module cache_data_array import cache_pkg::*; (
  input  logic                  clk,
  input  logic [IDX_W-1:0]      rd_index,
  input  logic [WAY_W-1:0]      rd_way,
  output logic [LINE_W-1:0]     rd_line,
  input  logic                  wr_en,
  input  logic [IDX_W-1:0]      wr_index,
  input  logic [WAY_W-1:0]      wr_way,
  input  logic [LINE_BYTES-1:0] wr_mask,
  input  logic [LINE_W-1:0]     wr_line
);

  // One line per set and way, addressed as {index, way}
  logic [LINE_W-1:0] lines [NUM_SETS*NUM_WAYS];

  assign rd_line = lines[{rd_index, rd_way}];

  // Fills come with a full mask, store hits with their size mask
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_mask[b]) begin
          lines[{wr_index, wr_way}][b*8 +: 8] <= wr_line[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- verilog/cache_miss_table.sv
`timescale 1ns/10ps

module cache_miss_table import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              alloc,
  input  cache_req_t        alloc_req,
  output logic              full,
  output logic              pending_match,
  input  logic [ADDR_W-1:0] probe_addr,
  input  logic              fill,
  input  logic [ADDR_W-1:0] fill_addr,
  output logic              head_valid,
  output cache_req_t        head_req
);

  // Slot 0 holds the oldest entry, same order as the bus reads
  logic [MSHR_DEPTH-1:0] vld;
  logic [MSHR_DEPTH-1:0] vld_shift;
  cache_req_t            ent [MSHR_DEPTH];
  logic                  pop;
  int                    slot;

  assign pop       = fill && vld[0] && line_of(fill_addr) == line_of(ent[0].addr);
  assign vld_shift = pop ? (vld >> 1) : vld;

  // First free slot after the head leaves
  always_comb begin
    slot = MSHR_DEPTH - 1;
    for (int i = MSHR_DEPTH - 1; i >= 0; i--) begin
      if (!vld_shift[i]) begin
        slot = i;
      end
    end
  end

  always_comb begin
    pending_match = 1'b0;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      if (vld[i] && line_of(ent[i].addr) == line_of(probe_addr)) begin
        pending_match = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld <= '0;
    end else begin
      vld <= vld_shift;
      if (alloc) begin
        vld[slot] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      for (int i = 0; i < MSHR_DEPTH - 1; i++) begin
        ent[i] <= ent[i+1];
      end
    end
    if (alloc) begin
      ent[slot] <= alloc_req;
    end
  end

  assign full       = &vld;
  assign head_valid = vld[0];
  assign head_req   = ent[0];

endmodule

//--- verilog/cache_output_align.sv
`timescale 1ns/10ps

module cache_output_align import cache_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              result_valid,
  input  cache_req_t        result_req,
  input  logic [LINE_W-1:0] result_line,
  output logic              resp_valid,
  output cache_resp_t       resp
);

  logic [OFF_W-1:0] off;
  logic [63:0]      half;
  logic [63:0]      shifted;
  logic [63:0]      sized;

  // Accesses stay inside one 8-byte half
  assign off     = result_req.addr[OFF_W-1:0];
  assign half    = off[3] ? result_line[LINE_W-1:64] : result_line[63:0];
  assign shifted = half >> {off[2:0], 3'b000};

  always_comb begin
    case (result_req.size)
      2'd0:    sized = {56'd0, shifted[7:0]};
      2'd1:    sized = {48'd0, shifted[15:0]};
      2'd2:    sized = {32'd0, shifted[31:0]};
      default: sized = shifted;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= result_valid;
    end
  end

  // Stores answer with zero data
  always_ff @(posedge clk) begin
    if (result_valid) begin
      resp.id    <= result_req.id;
      resp.write <= result_req.write;
      resp.data  <= result_req.write ? 64'd0 : sized;
    end
  end

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

  localparam int ADDR_W     = 15;
  localparam int LINE_BYTES = 16;
  localparam int NUM_SETS   = 4;
  localparam int TAG_W      = 9;
  localparam int NUM_WAYS   = 4;
  localparam int ID_W       = 4;
  localparam int MSHR_DEPTH = 2;

  // Address split and line width
  localparam int OFF_W  = $clog2(LINE_BYTES);
  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int WAY_W  = $clog2(NUM_WAYS);
  localparam int LINE_W = LINE_BYTES * 8;

  // Size code 0..3 means 1, 2, 4 or 8 bytes
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic              write;
    logic              uncached;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        size;
    logic [63:0]       wdata;
  } cache_req_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic            write;
    logic [63:0]     data;
  } cache_resp_t;

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] line;
    logic [LINE_BYTES-1:0] mask;
  } bus_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] line;
  } bus_resp_t;

  function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:OFF_W], OFF_W'(0)};
  endfunction

  function automatic logic [LINE_BYTES-1:0] size_mask(input logic [1:0] size,
                                                      input logic [OFF_W-1:0] offset);
    logic [LINE_BYTES-1:0] base;
    base = LINE_BYTES'((1 << (1 << size)) - 1);
    return base << offset;
  endfunction

  function automatic logic [LINE_W-1:0] place_bytes(input logic [63:0] data,
                                                    input logic [OFF_W-1:0] offset);
    return LINE_W'(data) << {offset, 3'b000};
  endfunction

  // Bytes of new_line under the mask, the rest from old_line
  function automatic logic [LINE_W-1:0] merge_bytes(input logic [LINE_W-1:0] old_line,
                                                    input logic [LINE_W-1:0] new_line,
                                                    input logic [LINE_BYTES-1:0] mask);
    logic [LINE_W-1:0] merged;
    for (int b = 0; b < LINE_BYTES; b++) begin
      merged[b*8 +: 8] = mask[b] ? new_line[b*8 +: 8] : old_line[b*8 +: 8];
    end
    return merged;
  endfunction

endpackage

//--- verilog/cache_subsystem.sv
`timescale 1ns/10ps

module cache_subsystem import cache_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req_valid,
  output logic        req_ready,
  input  cache_req_t  req,
  output logic        resp_valid,
  output cache_resp_t resp,
  output logic        bus_req_valid,
  input  logic        bus_req_ready,
  output bus_req_t    bus_req,
  input  logic        bus_resp_valid,
  input  bus_resp_t   bus_resp
);

  // Tag array
  logic [IDX_W-1:0] lookup_index;
  logic [TAG_W-1:0] lookup_tag;
  logic             hit;
  logic [WAY_W-1:0] hit_way;
  logic [WAY_W-1:0] victim_way;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  logic             install;
  logic [WAY_W-1:0] install_way;
  logic [TAG_W-1:0] install_tag;
  logic             touch;
  logic [WAY_W-1:0] touch_way;
  logic             set_dirty;

  // Data array
  logic [IDX_W-1:0]      rd_index;
  logic [WAY_W-1:0]      rd_way;
  logic [LINE_W-1:0]     rd_line;
  logic                  wr_en;
  logic [IDX_W-1:0]      wr_index;
  logic [WAY_W-1:0]      wr_way;
  logic [LINE_BYTES-1:0] wr_mask;
  logic [LINE_W-1:0]     wr_line;

  // Miss table
  logic              alloc;
  cache_req_t        alloc_req;
  logic              full;
  logic              pending_match;
  logic [ADDR_W-1:0] probe_addr;
  logic              fill;
  logic [ADDR_W-1:0] fill_addr;
  logic              head_valid;
  cache_req_t        head_req;

  // Bank to aligner
  logic              result_valid;
  cache_req_t        result_req;
  logic [LINE_W-1:0] result_line;

  cache_bank u_bank (
    .clk, .arst_n,
    .req_valid, .req, .req_ready,
    .bus_req_valid, .bus_req_ready, .bus_req,
    .bus_resp_valid, .bus_resp,
    .lookup_index, .lookup_tag, .hit, .hit_way,
    .victim_way, .victim_dirty, .victim_tag,
    .install, .install_way, .install_tag, .touch, .touch_way, .set_dirty,
    .rd_index, .rd_way, .rd_line,
    .wr_en, .wr_index, .wr_way, .wr_mask, .wr_line,
    .alloc, .alloc_req, .full, .pending_match, .probe_addr,
    .fill, .fill_addr, .head_valid, .head_req,
    .result_valid, .result_req, .result_line
  );

  cache_tag_array u_tags (
    .clk, .arst_n,
    .lookup_index, .lookup_tag, .hit, .hit_way,
    .victim_way, .victim_dirty, .victim_tag,
    .install, .install_way, .install_tag, .touch, .touch_way, .set_dirty
  );

  cache_data_array u_data (
    .clk,
    .rd_index, .rd_way, .rd_line,
    .wr_en, .wr_index, .wr_way, .wr_mask, .wr_line
  );

  cache_miss_table u_mshr (
    .clk, .arst_n,
    .alloc, .alloc_req, .full, .pending_match, .probe_addr,
    .fill, .fill_addr, .head_valid, .head_req
  );

  cache_output_align u_align (
    .clk, .arst_n,
    .result_valid, .result_req, .result_line,
    .resp_valid, .resp
  );

endmodule

//--- verilog/cache_tag_array.sv
`timescale 1ns/10ps

module cache_tag_array import cache_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [IDX_W-1:0] lookup_index,
  input  logic [TAG_W-1:0] lookup_tag,
  output logic             hit,
  output logic [WAY_W-1:0] hit_way,
  output logic [WAY_W-1:0] victim_way,
  output logic             victim_dirty,
  output logic [TAG_W-1:0] victim_tag,
  input  logic             install,
  input  logic [WAY_W-1:0] install_way,
  input  logic [TAG_W-1:0] install_tag,
  input  logic             touch,
  input  logic [WAY_W-1:0] touch_way,
  input  logic             set_dirty
);

  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty;
  logic [NUM_SETS-1:0][2:0]          plru;
  logic [TAG_W-1:0]                  tags [NUM_SETS][NUM_WAYS];

  logic [WAY_W-1:0] lru_way;
  logic [WAY_W-1:0] used_way;
  logic [2:0]       plru_next;

  // All four ways compared at once
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid[lookup_index][w] && tags[lookup_index][w] == lookup_tag) begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  // Bit 0 picks the half, bit 1 or 2 the way within it
  assign lru_way = plru[lookup_index][0] ? {1'b1, plru[lookup_index][2]}
                                         : {1'b0, plru[lookup_index][1]};

  // Lowest invalid way wins over the LRU choice
  always_comb begin
    victim_way = lru_way;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid[lookup_index][w]) begin
        victim_way = WAY_W'(w);
      end
    end
  end

  assign victim_dirty = valid[lookup_index][victim_way] && dirty[lookup_index][victim_way];
  assign victim_tag   = tags[lookup_index][victim_way];

  // Tree points away from the way just used
  assign used_way = install ? install_way : touch_way;

  always_comb begin
    plru_next    = plru[lookup_index];
    plru_next[0] = ~used_way[1];
    if (used_way[1]) begin
      plru_next[2] = ~used_way[0];
    end else begin
      plru_next[1] = ~used_way[0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
      dirty <= '0;
      plru  <= '0;
    end else if (install) begin
      valid[lookup_index][install_way] <= 1'b1;
      dirty[lookup_index][install_way] <= set_dirty;
      plru[lookup_index]               <= plru_next;
    end else if (touch) begin
      if (set_dirty) begin
        dirty[lookup_index][touch_way] <= 1'b1;
      end
      plru[lookup_index] <= plru_next;
    end
  end

  always_ff @(posedge clk) begin
    if (install) begin
      tags[lookup_index][install_way] <= install_tag;
    end
  end

endmodule
